// ==== mem_cfg_pkg.sv ====
package mem_cfg_pkg;

    // Memory geometry
    // --------------------------------------------------
    localparam int unsigned MEM_BYTES = 2048;

    // Byte index into the array, wraps inside the memory
    localparam int unsigned MEM_IDX_W = $clog2(MEM_BYTES);

    // Bus widths
    // --------------------------------------------------
    // Wider than the memory so that out-of-range requests can be issued
    localparam int unsigned ADDR_W      = 32;
    localparam int unsigned VALUE_W     = 64;
    localparam int unsigned VALUE_BYTES = VALUE_W / 8;
    localparam int unsigned INSTR_W     = 32;
    localparam int unsigned TAG_W       = 4;

    // Answer timing
    // --------------------------------------------------
    // Registers between the access unit and the output buffer
    localparam int unsigned LAT_STAGES = 2;

endpackage

// ==== mem_txn_pkg.sv ====
package mem_txn_pkg;

    // Access kinds
    typedef enum logic [1:0] {
        ACC_INSTR = 2'd0,
        ACC_LD    = 2'd1,
        ACC_ST    = 2'd2
    } acc_type_t;

    // Load/store width, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        LS_BYTE   = 2'd0,
        LS_HALF   = 2'd1,
        LS_WORD   = 2'd2,
        LS_DOUBLE = 2'd3
    } ls_size_t;

    // Cause values follow the RISC-V mcause numbering
    // E_UNKNOWN takes a reserved slot, E_NONE sits at the top
    typedef enum logic [3:0] {
        E_I_ADDR_MISALIGNED  = 4'h0,
        E_I_ACCESS_FAULT     = 4'h1,
        E_LD_ADDR_MISALIGNED = 4'h4,
        E_LD_ACCESS_FAULT    = 4'h5,
        E_ST_ADDR_MISALIGNED = 4'h6,
        E_ST_ACCESS_FAULT    = 4'h7,
        E_UNKNOWN            = 4'ha,
        E_NONE               = 4'hf
    } except_code_t;

    // Request from the core
    typedef struct packed {
        logic [mem_cfg_pkg::TAG_W-1:0]   tag;
        acc_type_t                       acc_type;
        ls_size_t                        ls_size;
        logic [mem_cfg_pkg::ADDR_W-1:0]  addr;
        logic [mem_cfg_pkg::VALUE_W-1:0] value;
    } mem_req_t;

    // Answer to the core
    typedef struct packed {
        logic [mem_cfg_pkg::TAG_W-1:0]   tag;
        acc_type_t                       acc_type;
        logic [mem_cfg_pkg::ADDR_W-1:0]  addr;
        logic [mem_cfg_pkg::VALUE_W-1:0] value;
        logic                            except_raised;
        except_code_t                    except_code;
    } mem_ans_t;

    // Number of bytes touched by an access of the given size
    function automatic logic [3:0] size_bytes(input ls_size_t size);
        return 4'd1 << size;
    endfunction

endpackage

// ==== mem_byte_array.sv ====
`timescale 1ns/100ps

module mem_byte_array (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [mem_cfg_pkg::ADDR_W-1:0]  fetch_addr_i,
    output logic [mem_cfg_pkg::INSTR_W-1:0] fetch_word_o,
    input  logic [mem_cfg_pkg::ADDR_W-1:0]  data_addr_i,
    input  mem_txn_pkg::ls_size_t           data_size_i,
    input  logic                            data_we_i,
    input  logic [mem_cfg_pkg::VALUE_W-1:0] data_wdata_i,
    output logic [mem_cfg_pkg::VALUE_W-1:0] data_rdata_o
);
    import mem_cfg_pkg::*;
    import mem_txn_pkg::*;

    // Little-endian byte storage
    logic [7:0]           mem_q [MEM_BYTES];
    logic [MEM_IDX_W-1:0] fetch_base;
    logic [MEM_IDX_W-1:0] data_base;
    logic [3:0]           data_nbytes;

    // Range checks live in the access unit, indices simply wrap here
    assign fetch_base  = fetch_addr_i[MEM_IDX_W-1:0];
    assign data_base   = data_addr_i[MEM_IDX_W-1:0];
    assign data_nbytes = size_bytes(data_size_i);

    // Read ports
    // --------------------------------------------------
    always_comb begin : p_fetch_read
        logic [MEM_IDX_W-1:0] idx;
        fetch_word_o = '0;
        for (int k = 0; k < INSTR_W / 8; k++) begin
            idx = fetch_base + MEM_IDX_W'(k);
            fetch_word_o[8*k +: 8] = mem_q[idx];
        end
    end

    // Bytes above the access size read as zero
    always_comb begin : p_data_read
        logic [MEM_IDX_W-1:0] idx;
        data_rdata_o = '0;
        for (int k = 0; k < VALUE_BYTES; k++) begin
            idx = data_base + MEM_IDX_W'(k);
            if (k < int'(data_nbytes)) begin
                data_rdata_o[8*k +: 8] = mem_q[idx];
            end
        end
    end

    // Write port
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin : p_mem_write
        if (!rst_n_i) begin
            for (int b = 0; b < MEM_BYTES; b++) begin
                mem_q[b] <= 8'h00;
            end
        end else if (data_we_i) begin
            for (int k = 0; k < VALUE_BYTES; k++) begin
                if (k < int'(data_nbytes)) begin
                    mem_q[data_base + MEM_IDX_W'(k)] <= data_wdata_i[8*k +: 8];
                end
            end
        end
    end

endmodule

// ==== mem_port_access.sv ====
`timescale 1ns/100ps

module mem_port_access #(
    parameter bit INSTR_ONLY = 1'b0
) (
    input  logic                            req_valid_i,
    input  logic                            req_ready_i,
    input  mem_txn_pkg::mem_req_t           req_i,
    output mem_txn_pkg::mem_ans_t           ans_o,
    output logic [mem_cfg_pkg::ADDR_W-1:0]  mem_addr_o,
    output mem_txn_pkg::ls_size_t           mem_size_o,
    output logic                            mem_we_o,
    output logic [mem_cfg_pkg::VALUE_W-1:0] mem_wdata_o,
    input  logic [mem_cfg_pkg::VALUE_W-1:0] mem_rdata_i
);
    import mem_cfg_pkg::*;
    import mem_txn_pkg::*;

    ls_size_t        eff_size;
    logic [3:0]      nbytes;
    logic [ADDR_W:0] last_byte;
    logic            misaligned;
    logic            out_of_range;
    logic            supported;
    logic            except_raised;
    except_code_t    except_code;

    // Request checks
    // --------------------------------------------------
    // A fetch is always one word, whatever ls_size says
    assign eff_size = (req_i.acc_type == ACC_INSTR) ? LS_WORD : req_i.ls_size;
    assign nbytes   = size_bytes(eff_size);

    assign misaligned = |(req_i.addr[2:0] & (nbytes[2:0] - 3'd1));

    // One extra bit so the sum cannot wrap
    assign last_byte    = {1'b0, req_i.addr} + (ADDR_W+1)'(nbytes) - 1;
    assign out_of_range = last_byte > (ADDR_W+1)'(MEM_BYTES - 1);

    always_comb begin : p_supported
        if (INSTR_ONLY) begin
            supported = (req_i.acc_type == ACC_INSTR);
        end else begin
            supported = req_i.acc_type inside {ACC_INSTR, ACC_LD, ACC_ST};
        end
    end

    // Misalignment wins over range, range over access type
    always_comb begin : p_except
        except_raised = 1'b1;
        except_code   = E_UNKNOWN;
        if (misaligned) begin
            case (req_i.acc_type)
                ACC_INSTR: except_code = E_I_ADDR_MISALIGNED;
                ACC_LD:    except_code = E_LD_ADDR_MISALIGNED;
                ACC_ST:    except_code = E_ST_ADDR_MISALIGNED;
                default:   except_code = E_UNKNOWN;
            endcase
        end else if (out_of_range) begin
            case (req_i.acc_type)
                ACC_INSTR: except_code = E_I_ACCESS_FAULT;
                ACC_LD:    except_code = E_LD_ACCESS_FAULT;
                ACC_ST:    except_code = E_ST_ACCESS_FAULT;
                default:   except_code = E_UNKNOWN;
            endcase
        end else if (!supported) begin
            except_code = E_UNKNOWN;
        end else begin
            except_raised = 1'b0;
            except_code   = E_NONE;
        end
    end

    // Answer
    // --------------------------------------------------
    always_comb begin : p_answer
        ans_o.tag           = req_i.tag;
        ans_o.acc_type      = req_i.acc_type;
        ans_o.addr          = req_i.addr;
        ans_o.value         = '0;
        ans_o.except_raised = except_raised;
        ans_o.except_code   = except_code;
        // Faulting requests and stores carry no data back
        if (!except_raised && req_i.acc_type != ACC_ST) begin
            ans_o.value = mem_rdata_i;
        end
    end

    // Memory side
    assign mem_addr_o  = req_i.addr;
    assign mem_size_o  = eff_size;
    assign mem_wdata_o = req_i.value;

    // Only a store that actually transfers may write
    assign mem_we_o = req_valid_i && req_ready_i && (req_i.acc_type == ACC_ST)
                      && !except_raised;

endmodule

// ==== mem_latency_pipe.sv ====
`timescale 1ns/100ps

module mem_latency_pipe #(
    parameter type         DATA_T = logic,
    parameter int unsigned DEPTH  = 1
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  flush_i,
    input  logic  en_i,
    input  logic  valid_i,
    input  DATA_T data_i,
    output logic  valid_o,
    output DATA_T data_o
);

    generate
        if (DEPTH == 0) begin : g_bypass
            assign valid_o = valid_i;
            assign data_o  = data_i;
        end else begin : g_stages
            logic [DEPTH-1:0] valid_q;
            DATA_T            data_q [DEPTH];

            // Valid bits, cleared by reset and flush
            always_ff @(posedge clk_i) begin : p_valid
                if (!rst_n_i) begin
                    valid_q <= '0;
                end else if (flush_i) begin
                    valid_q <= '0;
                end else if (en_i) begin
                    valid_q[0] <= valid_i;
                    for (int i = 1; i < DEPTH; i++) begin
                        valid_q[i] <= valid_q[i-1];
                    end
                end
            end

            always_ff @(posedge clk_i) begin : p_data
                if (en_i) begin
                    data_q[0] <= data_i;
                    for (int i = 1; i < DEPTH; i++) begin
                        data_q[i] <= data_q[i-1];
                    end
                end
            end

            assign valid_o = valid_q[DEPTH-1];
            assign data_o  = data_q[DEPTH-1];
        end
    endgenerate

endmodule

// ==== mem_spill_cell.sv ====
`timescale 1ns/100ps

module mem_spill_cell #(
    parameter type DATA_T = logic
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  flush_i,
    input  logic  valid_i,
    output logic  ready_o,
    input  DATA_T data_i,
    output logic  valid_o,
    input  logic  ready_i,
    output DATA_T data_o
);

    logic  main_valid;
    logic  spill_valid;
    DATA_T main_data;
    DATA_T spill_data;
    logic  accept;
    logic  drain;

    // Handshakes
    // --------------------------------------------------
    // Ready comes from local state only, flush blocks both sides
    assign ready_o = !spill_valid && !flush_i;
    assign valid_o = main_valid && !flush_i;
    assign data_o  = main_data;

    assign accept = valid_i && ready_o;
    assign drain  = valid_o && ready_i;

    // Occupancy
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin : p_state
        if (!rst_n_i) begin
            main_valid  <= 1'b0;
            spill_valid <= 1'b0;
        end else if (flush_i) begin
            main_valid  <= 1'b0;
            spill_valid <= 1'b0;
        end else if (drain) begin
            // Spill entry moves up first, no accept possible then
            if (spill_valid) begin
                spill_valid <= 1'b0;
            end else begin
                main_valid <= accept;
            end
        end else if (accept) begin
            if (main_valid) begin
                spill_valid <= 1'b1;
            end else begin
                main_valid <= 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin : p_data
        if (drain && spill_valid) begin
            main_data <= spill_data;
        end else if (accept && (drain || !main_valid)) begin
            main_data <= data_i;
        end
        if (accept && main_valid && !drain) begin
            spill_data <= data_i;
        end
    end

endmodule

// ==== mem_emu_top.sv ====
`timescale 1ns/100ps

module mem_emu_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // Instruction port
    input  logic                  ins_req_valid_i,
    output logic                  ins_req_ready_o,
    input  mem_txn_pkg::mem_req_t ins_req_i,
    output logic                  ins_ans_valid_o,
    input  logic                  ins_ans_ready_i,
    output mem_txn_pkg::mem_ans_t ins_ans_o,

    // Data port
    input  logic                  data_req_valid_i,
    output logic                  data_req_ready_o,
    input  mem_txn_pkg::mem_req_t data_req_i,
    output logic                  data_ans_valid_o,
    input  logic                  data_ans_ready_i,
    output mem_txn_pkg::mem_ans_t data_ans_o
);
    import mem_cfg_pkg::*;
    import mem_txn_pkg::*;

    // Shared array
    logic [ADDR_W-1:0]  fetch_addr;
    logic [INSTR_W-1:0] fetch_word;
    logic [ADDR_W-1:0]  data_addr;
    ls_size_t           data_size;
    logic               data_we;
    logic [VALUE_W-1:0] data_wdata;
    logic [VALUE_W-1:0] data_rdata;

    // Per-port answer path
    mem_ans_t ins_ans;
    mem_ans_t ins_pipe_ans;
    logic     ins_pipe_valid;
    mem_ans_t data_ans;
    mem_ans_t data_pipe_ans;
    logic     data_pipe_valid;

    mem_byte_array u_mem_byte_array (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fetch_addr_i (fetch_addr),
        .fetch_word_o (fetch_word),
        .data_addr_i  (data_addr),
        .data_size_i  (data_size),
        .data_we_i    (data_we),
        .data_wdata_i (data_wdata),
        .data_rdata_o (data_rdata)
    );

    // Instruction chain
    // --------------------------------------------------
    // Read-only, so size, strobe and write data stay open
    mem_port_access #(
        .INSTR_ONLY (1'b1)
    ) u_ins_access (
        .req_valid_i (ins_req_valid_i),
        .req_ready_i (ins_req_ready_o),
        .req_i       (ins_req_i),
        .ans_o       (ins_ans),
        .mem_addr_o  (fetch_addr),
        .mem_size_o  (),
        .mem_we_o    (),
        .mem_wdata_o (),
        .mem_rdata_i ({{(VALUE_W-INSTR_W){1'b0}}, fetch_word})
    );

    mem_latency_pipe #(
        .DATA_T (mem_ans_t),
        .DEPTH  (LAT_STAGES)
    ) u_ins_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .en_i    (ins_req_ready_o),
        .valid_i (ins_req_valid_i),
        .data_i  (ins_ans),
        .valid_o (ins_pipe_valid),
        .data_o  (ins_pipe_ans)
    );

    mem_spill_cell #(
        .DATA_T (mem_ans_t)
    ) u_ins_spill (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (ins_pipe_valid),
        .ready_o (ins_req_ready_o),
        .data_i  (ins_pipe_ans),
        .valid_o (ins_ans_valid_o),
        .ready_i (ins_ans_ready_i),
        .data_o  (ins_ans_o)
    );

    // Data chain
    // --------------------------------------------------
    mem_port_access #(
        .INSTR_ONLY (1'b0)
    ) u_data_access (
        .req_valid_i (data_req_valid_i),
        .req_ready_i (data_req_ready_o),
        .req_i       (data_req_i),
        .ans_o       (data_ans),
        .mem_addr_o  (data_addr),
        .mem_size_o  (data_size),
        .mem_we_o    (data_we),
        .mem_wdata_o (data_wdata),
        .mem_rdata_i (data_rdata)
    );

    mem_latency_pipe #(
        .DATA_T (mem_ans_t),
        .DEPTH  (LAT_STAGES)
    ) u_data_pipe (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .en_i    (data_req_ready_o),
        .valid_i (data_req_valid_i),
        .data_i  (data_ans),
        .valid_o (data_pipe_valid),
        .data_o  (data_pipe_ans)
    );

    mem_spill_cell #(
        .DATA_T (mem_ans_t)
    ) u_data_spill (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .valid_i (data_pipe_valid),
        .ready_o (data_req_ready_o),
        .data_i  (data_pipe_ans),
        .valid_o (data_ans_valid_o),
        .ready_i (data_ans_ready_i),
        .data_o  (data_ans_o)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int unsigned PERIOD_NS    = 20,
    parameter int unsigned RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin : p_clock
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release lands just after a rising edge, like the other inputs
    initial begin : p_reset
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_n_o = 1'b1;
    end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/100ps

module tb_checker (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  strict_lat_i,
    input  logic                  ins_req_valid_i,
    input  logic                  ins_req_ready_i,
    input  mem_txn_pkg::mem_req_t ins_req_i,
    input  logic                  ins_ans_valid_i,
    input  logic                  ins_ans_ready_i,
    input  mem_txn_pkg::mem_ans_t ins_ans_i,
    input  logic                  data_req_valid_i,
    input  logic                  data_req_ready_i,
    input  mem_txn_pkg::mem_req_t data_req_i,
    input  logic                  data_ans_valid_i,
    input  logic                  data_ans_ready_i,
    input  mem_txn_pkg::mem_ans_t data_ans_i,
    output int                    error_count_o,
    output int                    ins_pending_o,
    output int                    data_pending_o
);
    import mem_cfg_pkg::*;
    import mem_txn_pkg::*;

    // Reference memory and expected answers in request order
    logic [7:0]  model_mem [MEM_BYTES];
    mem_ans_t    ins_exp_q[$];
    mem_ans_t    data_exp_q[$];
    int unsigned ins_cyc_q[$];
    int unsigned data_cyc_q[$];
    int unsigned cycle;
    int          errors = 0;
    int          compared = 0;
    bit          after_reset;

    assign error_count_o = errors;

    // Reference model
    // --------------------------------------------------
    // A fetch is one word regardless of ls_size
    function automatic int access_bytes(input mem_req_t req);
        if (req.acc_type == ACC_INSTR) begin
            return 4;
        end
        case (req.ls_size)
            LS_BYTE: return 1;
            LS_HALF: return 2;
            LS_WORD: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic except_code_t fault_code(input acc_type_t acc, input bit misaligned);
        case (acc)
            ACC_INSTR: return misaligned ? E_I_ADDR_MISALIGNED : E_I_ACCESS_FAULT;
            ACC_LD:    return misaligned ? E_LD_ADDR_MISALIGNED : E_LD_ACCESS_FAULT;
            ACC_ST:    return misaligned ? E_ST_ADDR_MISALIGNED : E_ST_ACCESS_FAULT;
            default:   return E_UNKNOWN;
        endcase
    endfunction

    function automatic mem_ans_t model_answer(input mem_req_t req, input bit instr_only);
        mem_ans_t    ans;
        int          nb;
        logic [63:0] last;
        bit          supported;
        nb        = access_bytes(req);
        last      = 64'(req.addr) + 64'(nb) - 64'd1;
        supported = instr_only ? (req.acc_type == ACC_INSTR)
                               : (req.acc_type inside {ACC_INSTR, ACC_LD, ACC_ST});
        ans.tag           = req.tag;
        ans.acc_type      = req.acc_type;
        ans.addr          = req.addr;
        ans.value         = '0;
        ans.except_raised = 1'b1;
        ans.except_code   = E_UNKNOWN;
        if (req.addr % nb != 0) begin
            ans.except_code = fault_code(req.acc_type, 1'b1);
        end else if (last >= 64'(MEM_BYTES)) begin
            ans.except_code = fault_code(req.acc_type, 1'b0);
        end else if (supported) begin
            ans.except_raised = 1'b0;
            ans.except_code   = E_NONE;
            if (req.acc_type != ACC_ST) begin
                for (int k = 0; k < nb; k++) begin
                    ans.value[8*k +: 8] = model_mem[int'(req.addr) + k];
                end
            end
        end
        return ans;
    endfunction

    task automatic model_store(input mem_req_t req);
        int nb;
        nb = access_bytes(req);
        for (int k = 0; k < nb; k++) begin
            model_mem[int'(req.addr) + k] = req.value[8*k +: 8];
        end
    endtask

    // Comparison
    // --------------------------------------------------
    task automatic check_field(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("ERROR %s expected 0x%h got 0x%h at %0t", name, exp_v, act_v, $time);
        end
    endtask

    task automatic take_answer(input bit is_data, input mem_ans_t act);
        mem_ans_t    exp_a;
        int unsigned t0;
        string       sig;
        sig = is_data ? "data_ans_o" : "ins_ans_o";
        if (is_data) begin
            exp_a = data_exp_q.pop_front();
            t0    = data_cyc_q.pop_front();
        end else begin
            exp_a = ins_exp_q.pop_front();
            t0    = ins_cyc_q.pop_front();
        end
        check_field({sig, ".tag"}, 64'(exp_a.tag), 64'(act.tag));
        check_field({sig, ".acc_type"}, 64'(exp_a.acc_type), 64'(act.acc_type));
        check_field({sig, ".addr"}, 64'(exp_a.addr), 64'(act.addr));
        check_field({sig, ".value"}, exp_a.value, act.value);
        check_field({sig, ".except_raised"}, 64'(exp_a.except_raised), 64'(act.except_raised));
        check_field({sig, ".except_code"}, 64'(exp_a.except_code), 64'(act.except_code));
        // Only meaningful while the answer side never stalls
        if (strict_lat_i && (cycle - t0 != LAT_STAGES + 1)) begin
            errors++;
            $display("Answer on %s came %0d cycles after its request instead of %0d",
                     sig, cycle - t0, LAT_STAGES + 1);
        end
        compared++;
    endtask

    task automatic print_summary();
        $display("Checker summary: %0d answers compared, %0d still pending, %0d errors",
                 compared, ins_exp_q.size() + data_exp_q.size(), errors);
    endtask

    // Port monitor
    // --------------------------------------------------
    always @(posedge clk_i) begin : p_check
        mem_ans_t exp_a;
        if (!rst_n_i) begin
            for (int b = 0; b < MEM_BYTES; b++) begin
                model_mem[b] = 8'h00;
            end
            ins_exp_q.delete();
            data_exp_q.delete();
            ins_cyc_q.delete();
            data_cyc_q.delete();
            cycle       = 0;
            after_reset = 1'b1;
        end else begin
            cycle++;
            if (after_reset && !(ins_req_ready_i && data_req_ready_i)) begin
                errors++;
                $display("Request ready was low in the first cycle after reset");
            end
            after_reset = 1'b0;
            if (flush_i && (ins_req_ready_i || data_req_ready_i
                            || ins_ans_valid_i || data_ans_valid_i)) begin
                errors++;
                $display("A handshake signal was high during flush at %0t", $time);
            end

            // Answers first, they leave before any new request arrives
            if (ins_ans_valid_i && ins_exp_q.size() == 0) begin
                errors++;
                $display("Answer valid on the instruction port with nothing outstanding");
            end else if (ins_ans_valid_i && ins_ans_ready_i) begin
                take_answer(1'b0, ins_ans_i);
            end
            if (data_ans_valid_i && data_exp_q.size() == 0) begin
                errors++;
                $display("Answer valid on the data port with nothing outstanding");
            end else if (data_ans_valid_i && data_ans_ready_i) begin
                take_answer(1'b1, data_ans_i);
            end

            if (flush_i) begin
                ins_exp_q.delete();
                data_exp_q.delete();
                ins_cyc_q.delete();
                data_cyc_q.delete();
            end else begin
                // Fetch sees memory as it was before a store at the same edge
                if (ins_req_valid_i && ins_req_ready_i) begin
                    exp_a = model_answer(ins_req_i, 1'b1);
                    ins_exp_q.push_back(exp_a);
                    ins_cyc_q.push_back(cycle);
                end
                if (data_req_valid_i && data_req_ready_i) begin
                    exp_a = model_answer(data_req_i, 1'b0);
                    data_exp_q.push_back(exp_a);
                    data_cyc_q.push_back(cycle);
                    if (data_req_i.acc_type == ACC_ST && !exp_a.except_raised) begin
                        model_store(data_req_i);
                    end
                end
            end
        end
        ins_pending_o  = ins_exp_q.size();
        data_pending_o = data_exp_q.size();
    end

endmodule

// ==== tb_mem_emu.sv ====
`timescale 1ns/100ps

module tb_mem_emu;
    import mem_cfg_pkg::*;
    import mem_txn_pkg::*;

    localparam int REQS_PER_PORT  = 2000;
    localparam int WARMUP_REQS    = 40;
    localparam int TIMEOUT_CYCLES = 10 * 2 * REQS_PER_PORT;

    logic     clk;
    logic     rst_n;
    logic     flush;
    logic     ins_req_valid;
    logic     ins_req_ready;
    mem_req_t ins_req;
    logic     ins_ans_valid;
    logic     ins_ans_ready;
    mem_ans_t ins_ans;
    logic     data_req_valid;
    logic     data_req_ready;
    mem_req_t data_req;
    logic     data_ans_valid;
    logic     data_ans_ready;
    mem_ans_t data_ans;

    logic        strict_lat;
    logic        random_ready;
    int          error_count;
    int          ins_pending;
    int          data_pending;
    int          ins_sent;
    int unsigned cycle_cnt;

    tb_clk_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (10)
    ) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mem_emu_top u_mem_emu_top (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .flush_i          (flush),
        .ins_req_valid_i  (ins_req_valid),
        .ins_req_ready_o  (ins_req_ready),
        .ins_req_i        (ins_req),
        .ins_ans_valid_o  (ins_ans_valid),
        .ins_ans_ready_i  (ins_ans_ready),
        .ins_ans_o        (ins_ans),
        .data_req_valid_i (data_req_valid),
        .data_req_ready_o (data_req_ready),
        .data_req_i       (data_req),
        .data_ans_valid_o (data_ans_valid),
        .data_ans_ready_i (data_ans_ready),
        .data_ans_o       (data_ans)
    );

    tb_checker u_checker (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .flush_i          (flush),
        .strict_lat_i     (strict_lat),
        .ins_req_valid_i  (ins_req_valid),
        .ins_req_ready_i  (ins_req_ready),
        .ins_req_i        (ins_req),
        .ins_ans_valid_i  (ins_ans_valid),
        .ins_ans_ready_i  (ins_ans_ready),
        .ins_ans_i        (ins_ans),
        .data_req_valid_i (data_req_valid),
        .data_req_ready_i (data_req_ready),
        .data_req_i       (data_req),
        .data_ans_valid_i (data_ans_valid),
        .data_ans_ready_i (data_ans_ready),
        .data_ans_i       (data_ans),
        .error_count_o    (error_count),
        .ins_pending_o    (ins_pending),
        .data_pending_o   (data_pending)
    );

    // Stimulus helpers
    // --------------------------------------------------
    function automatic mem_req_t random_request(input bit is_data);
        mem_req_t    req;
        int          nb;
        int          pick;
        logic [31:0] base;
        req.tag     = TAG_W'($urandom);
        req.ls_size = ls_size_t'($urandom % 4);
        req.value   = {$urandom, $urandom};
        if (is_data) begin
            req.acc_type = ($urandom % 2) ? ACC_ST : ACC_LD;
        end else begin
            // Rare loads on the fetch port exercise the unsupported case
            req.acc_type = ($urandom % 32 == 0) ? ACC_LD : ACC_INSTR;
        end
        nb = (req.acc_type == ACC_INSTR) ? 4 : (1 << req.ls_size);
        // Half the traffic in a small window so loads meet earlier stores
        base = ($urandom % 2) ? $urandom % 128 : $urandom % MEM_BYTES;
        pick = $urandom % 100;
        if (pick < 10) begin
            base     = ($urandom % 4 == 0) ? $urandom : MEM_BYTES + $urandom % 512;
            req.addr = base & ~(nb - 1);
        end else if (pick < 20) begin
            req.addr = base | 32'd1;
        end else begin
            req.addr = base & ~(nb - 1);
        end
        return req;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic send_request(input bit is_data, input mem_req_t req);
        bit done;
        done = 1'b0;
        if (is_data) begin
            data_req       = req;
            data_req_valid = 1'b1;
        end else begin
            ins_req       = req;
            ins_req_valid = 1'b1;
        end
        while (!done) begin
            @(posedge clk);
            done = is_data ? (data_req_valid && data_req_ready)
                           : (ins_req_valid && ins_req_ready);
            #2;
        end
        if (is_data) begin
            data_req_valid = 1'b0;
        end else begin
            ins_req_valid = 1'b0;
            ins_sent++;
        end
    endtask

    task automatic run_port(input bit is_data, input int count);
        mem_req_t req;
        for (int n = 0; n < count; n++) begin
            req = random_request(is_data);
            if ($urandom % 5 == 0) begin
                repeat (1 + $urandom % 3) next_cycle();
            end
            send_request(is_data, req);
        end
    endtask

    // Three flushes spread over the random phase
    task automatic flush_episodes();
        for (int k = 1; k <= 3; k++) begin
            wait (ins_sent >= WARMUP_REQS + k * 480);
            flush = 1'b1;
            repeat (1 + $urandom % 3) next_cycle();
            flush = 1'b0;
        end
    endtask

    // Answer side back-pressure
    always @(posedge clk) begin : p_ans_ready
        bit rnd;
        rnd = random_ready;
        #2;
        if (rnd) begin
            ins_ans_ready  = ($urandom % 10) < 6;
            data_ans_ready = ($urandom % 10) < 6;
        end else begin
            ins_ans_ready  = 1'b1;
            data_ans_ready = 1'b1;
        end
    end

    // Sequence
    // --------------------------------------------------
    initial begin : p_main
        void'($urandom(32'hb783ec72));
        flush          = 1'b0;
        ins_req_valid  = 1'b0;
        ins_req        = '0;
        ins_ans_ready  = 1'b1;
        data_req_valid = 1'b0;
        data_req       = '0;
        data_ans_ready = 1'b1;
        strict_lat     = 1'b1;
        random_ready   = 1'b0;
        ins_sent       = 0;
        wait (rst_n === 1'b1);
        next_cycle();

        // No stalls here, so every answer must keep the nominal latency
        fork
            run_port(1'b0, WARMUP_REQS);
            run_port(1'b1, WARMUP_REQS);
        join
        wait (ins_pending == 0 && data_pending == 0);
        next_cycle();

        strict_lat   = 1'b0;
        random_ready = 1'b1;
        fork
            run_port(1'b0, REQS_PER_PORT - WARMUP_REQS);
            run_port(1'b1, REQS_PER_PORT - WARMUP_REQS);
            flush_episodes();
        join
        random_ready = 1'b0;
        wait (ins_pending == 0 && data_pending == 0);
        repeat (5) next_cycle();

        u_checker.print_summary();
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Ten times the total request count of both ports
    initial begin : p_timeout
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        u_checker.print_summary();
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
mem_cfg_pkg.sv
mem_txn_pkg.sv
mem_byte_array.sv
mem_port_access.sv
mem_latency_pipe.sv
mem_spill_cell.sv
mem_emu_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_mem_emu.sv

// ==== Bender.yml ====
package:
  name: mem_emu

sources:
  # Packages first, then the design bottom-up
  - mem_cfg_pkg.sv
  - mem_txn_pkg.sv
  - mem_byte_array.sv
  - mem_port_access.sv
  - mem_latency_pipe.sv
  - mem_spill_cell.sv
  - mem_emu_top.sv

  # Testbench, top module tb_mem_emu
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_checker.sv
      - tb_mem_emu.sv
